/* common/pipe_ctrl_pkg.sv */
`default_nettype none

package pipe_ctrl_pkg;

    typedef logic [31:0] word_t;    // address or instruction word
    typedef logic [4:0]  reg_idx_t; // x0..x31 / v0..v31
    typedef logic [7:0]  velem_t;   // element number inside a vector micro-op

    // vsetvl serialization
    typedef enum logic {
        VSET_IDLE = 1'b0,
        VSET_WAIT = 1'b1 // vsetvl in flight, decode held until it executes
    } vset_state_t;

    // one decode queue entry
    typedef struct packed {
        word_t pc;
        word_t insn;
    } fetch_pkt_t;

    typedef struct packed {
        reg_idx_t rs1_e;
        reg_idx_t rs2_e;
        reg_idx_t rd_m;
        logic     reg_write; // mem stage writes rd_m
        logic     dren;
        logic     dwen;
        logic     csr_read;  // csr result only known in mem
    } scalar_hz_t;

    typedef struct packed {
        reg_idx_t vd;
        reg_idx_t vs1;
        reg_idx_t vs2;
        reg_idx_t vd_ex;
        logic     vregwen;
        logic     vs1_used;
        logic     vs2_used;
        logic     vd_used;
        logic     ex_mask_dep; // execute reads v0 as mask
        logic     vbusy;
    } vec_hz_t;

    typedef struct packed {
        logic iren;
        logic i_mem_busy;
        logic rv32c_ready;
        logic d_mem_busy;
        logic ex_busy;
        logic fence_stall;
        logic serializer_stall;
        logic coalescer_stall;
        logic halt;
        logic jump;
        logic branch;
        logic mispredict;
        logic ifence;
        logic not_interruptible;
    } stage_status_t;

    // synchronous fault sources, in cause order
    typedef struct packed {
        logic fault_insn;
        logic mal_insn;
        logic illegal_insn;
        logic fault_l;
        logic mal_l;
        logic fault_s;
        logic mal_s;
        logic breakpoint;
        logic env;
        logic wfi;
    } fault_t;

    typedef struct packed {
        word_t  pc_f;
        word_t  pc_decode;
        word_t  pc_e;
        word_t  pc_m;
        logic   valid_decode;
        logic   valid_e;
        logic   valid_m;
        logic   vvalid_e;
        velem_t velem_num_e;
        velem_t velem_num_m;
        logic   vmem_last_elem;
        logic   vuop_last;
        logic   keep_vstart_e;
        logic   keep_vstart_m;
    } pc_track_t;

    typedef struct packed {
        logic  intr;
        logic  ret;
        logic  insert_pc;
        word_t priv_pc;
        logic  prot_fault_l;
        logic  prot_fault_s;
    } prv_in_t;

    typedef struct packed {
        logic  pc_en;
        logic  npc_sel;
        logic  if_ex_flush;
        logic  if_ex_stall;
        logic  flush_queue;
        logic  stall_queue;
        logic  stall_decode;
        logic  flush_decode;
        logic  ex_mem_flush;
        logic  ex_mem_stall;
        logic  mem_use_stall;
        logic  vmem_use_stall;
        logic  vmask_calc_stall;
        logic  suppress_iren;
        logic  suppress_data;
        logic  rollback;
        logic  insert_priv_pc;
        word_t priv_pc;
    } stage_ctrl_t;

    typedef struct packed {
        fault_t fault;      // protection faults already merged in
        word_t  epc;
        word_t  badaddr;
        velem_t velem_num;
        logic   set_vstart;
        logic   vuop_last;
        logic   pipe_clear;
        logic   wb_enable;
        logic   ret;
    } trap_req_t;

endpackage

`default_nettype wire

/* src/insn_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      push,
    input  pipe_ctrl_pkg::fetch_pkt_t wdata,
    input  logic                      pop,
    input  logic                      flush,
    output pipe_ctrl_pkg::fetch_pkt_t rdata,
    output logic                      empty,
    output logic                      full,
    output logic                      accepted_push
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    pipe_ctrl_pkg::fetch_pkt_t mem [QUEUE_DEPTH];

    ptr_t rd_ptr, wr_ptr;
    cnt_t count;
    logic do_pop;

    assign empty         = (count == '0);
    assign full          = (count == cnt_t'(QUEUE_DEPTH));
    assign accepted_push = push && !full; // full queue drops the packet
    assign do_pop        = pop && !empty;
    assign rdata         = mem[rd_ptr]; // head, valid when not empty

    // pointer step with wrap, depth need not be a power of two
    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(QUEUE_DEPTH - 1))
            return '0;
        return p + ptr_t'(1);
    endfunction

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin // redirect drops everything in flight
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (accepted_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (accepted_push && !do_pop)
                count <= count + cnt_t'(1);
            else if (do_pop && !accepted_push)
                count <= count - cnt_t'(1);
        end
    end

    // storage only, entries are dead until the count covers them
    always_ff @(posedge CLK) begin
        if (accepted_push && !flush)
            mem[wr_ptr] <= wdata;
    end

endmodule

`default_nettype wire

/* hazard/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic                         CLK,
    input  logic                         nRST,
    input  pipe_ctrl_pkg::scalar_hz_t    scalar,
    input  pipe_ctrl_pkg::vec_hz_t       vec,
    input  pipe_ctrl_pkg::stage_status_t status,
    input  pipe_ctrl_pkg::prv_in_t       prv,
    input  logic                         exception,  // from trap select
    input  logic                         intr_taken,
    input  logic                         full,       // decode queue
    input  logic                         accepted_push,
    input  logic                         empty,
    input  logic                         vsetvl_dec,
    input  logic                         vsetvl_ex,
    output pipe_ctrl_pkg::stage_ctrl_t   ctrl,
    output logic                         dmem_wait,
    output logic                         pop
);

    logic rs1_match, rs2_match;
    logic cannot_forward;
    logic dmem_access;
    logic branch_jump;
    logic wait_for_imem;
    logic ex_flush_hazard;
    logic mem_use_stall;
    logic vex_stall;
    logic ex_mem_stall;
    logic stall_queue;
    logic flush_queue;
    logic stall_decode;
    logic if_ex_stall;
    logic suppress_iren;

    pipe_ctrl_pkg::vset_state_t vset_state, vset_next;

    // scalar load/csr use: result only exists after mem, no forwarding path
    assign rs1_match      = (scalar.rs1_e == scalar.rd_m) && (scalar.rd_m != '0);
    assign rs2_match      = (scalar.rs2_e == scalar.rd_m) && (scalar.rd_m != '0);
    assign cannot_forward = scalar.dren || scalar.csr_read;
    assign mem_use_stall  = scalar.reg_write && cannot_forward && (rs1_match || rs2_match);

    // vector dependency against the op in execute, checked in order
    always_comb begin
        vex_stall = 1'b0;
        if (vec.vregwen) begin
            if (vec.vd == vec.vs1 && vec.vs1_used)
                vex_stall = 1'b1;
            else if (vec.vd == vec.vs2 && vec.vs2_used)
                vex_stall = 1'b1;
            else if (vec.ex_mask_dep && vec.vd == '0) // v0 is the mask register
                vex_stall = 1'b1;
            else if (vec.vd == vec.vd_ex && vec.vd_used)
                vex_stall = 1'b1;
        end
    end

    assign dmem_access = scalar.dren || scalar.dwen;
    assign branch_jump = status.jump || (status.branch && status.mispredict);

    // trap, return and ifence all drain the front of the pipe
    // an interrupt waits for the mem access and for an interruptible op
    assign ex_flush_hazard = ((intr_taken || exception) && !dmem_wait
                              && !status.not_interruptible)
                           || exception
                           || prv.ret
                           || (status.ifence && !status.fence_stall);

    // no fetch request when a redirect is about to happen
    assign suppress_iren = branch_jump || ex_flush_hazard || prv.ret || prv.insert_pc;
    // compressed insn already complete, imem latency does not matter
    assign wait_for_imem = status.iren && status.i_mem_busy && !suppress_iren
                        && !status.rv32c_ready;
    assign dmem_wait     = dmem_access && status.d_mem_busy && !exception;

    // mem stage waiting holds everything behind it
    assign ex_mem_stall = dmem_wait
                       || status.fence_stall
                       || status.serializer_stall
                       || status.coalescer_stall
                       || status.halt;

    assign stall_queue = ex_mem_stall
                      || (status.ex_busy && !ex_flush_hazard && !branch_jump) // redirect wins
                      || mem_use_stall
                      || status.fence_stall
                      || vex_stall;

    assign flush_queue  = ex_flush_hazard || branch_jump;
    assign stall_decode = (full && !flush_queue) || (vset_state == pipe_ctrl_pkg::VSET_WAIT);
    assign if_ex_stall  = stall_decode || status.fence_stall || (vec.vbusy && !flush_queue);

    // queue head moves on to execute only when decode is free
    assign pop = !empty && !stall_decode && !if_ex_stall;

    // vsetvl must reach execute before younger insns are decoded
    always_comb begin
        vset_next = vset_state;
        if (flush_queue) // decode flush
            vset_next = pipe_ctrl_pkg::VSET_IDLE;
        else if (vsetvl_ex)
            vset_next = pipe_ctrl_pkg::VSET_IDLE;
        else if (accepted_push && vsetvl_dec)
            vset_next = pipe_ctrl_pkg::VSET_WAIT;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            vset_state <= pipe_ctrl_pkg::VSET_IDLE;
        else
            vset_state <= vset_next;
    end

    // pc holds on any stall behind fetch unless a redirect forces it
    assign ctrl.pc_en = (!if_ex_stall && !stall_queue && !wait_for_imem)
                     || branch_jump
                     || prv.insert_pc
                     || prv.ret;
    assign ctrl.npc_sel       = branch_jump;
    assign ctrl.if_ex_flush   = branch_jump || ex_flush_hazard || wait_for_imem; // bubble on slow fetch
    assign ctrl.if_ex_stall   = if_ex_stall;
    assign ctrl.flush_queue   = flush_queue;
    assign ctrl.stall_queue   = stall_queue;
    assign ctrl.stall_decode  = stall_decode;
    assign ctrl.flush_decode  = flush_queue;
    // bubble into mem for redirects and dependencies, never while mem holds
    assign ctrl.ex_mem_flush  = (ex_flush_hazard || branch_jump || stall_queue || vex_stall)
                             && !ex_mem_stall;
    assign ctrl.ex_mem_stall  = ex_mem_stall;
    assign ctrl.mem_use_stall = mem_use_stall;
    assign ctrl.vmem_use_stall   = vex_stall;
    assign ctrl.vmask_calc_stall = ex_mem_stall || mem_use_stall || status.fence_stall
                                || vex_stall;
    assign ctrl.suppress_iren  = suppress_iren;
    assign ctrl.suppress_data  = exception; // keep a faulting access off the bus
    assign ctrl.rollback       = status.ifence && !status.fence_stall; // refetch after ifence
    assign ctrl.insert_priv_pc = prv.insert_pc;
    assign ctrl.priv_pc        = prv.priv_pc;

endmodule

`default_nettype wire

/* hazard/trap_select.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_select (
    input  pipe_ctrl_pkg::fault_t    faults,
    input  pipe_ctrl_pkg::prv_in_t   prv,
    input  pipe_ctrl_pkg::pc_track_t pcs,
    input  pipe_ctrl_pkg::word_t     badaddr,
    input  logic                     dmem_wait,  // from hazard unit
    input  logic                     if_ex_stall,
    input  logic                     jump,
    input  logic                     branch,
    input  logic                     not_interruptible,
    output logic                     exception,
    output logic                     intr_taken,
    output pipe_ctrl_pkg::trap_req_t trap
);

    logic take_m;     // report the mem stage insn
    logic vstart_sel; // vstart update for the chosen stage

    assign exception  = (|faults) || prv.prot_fault_l || prv.prot_fault_s;
    assign intr_taken = prv.intr && !exception; // a fault always goes first

    // interrupt lets the current element finish, so on the last element
    // of a micro-op the mem insn is done and execute is the restart point
    assign take_m = pcs.valid_m && (!intr_taken || !pcs.vmem_last_elem);

    always_comb begin
        if (take_m)
            trap.epc = pcs.pc_m;
        else if (pcs.valid_e)
            trap.epc = pcs.pc_e;
        else if (pcs.valid_decode)
            trap.epc = pcs.pc_decode;
        else
            trap.epc = pcs.pc_f; // nothing valid behind fetch
    end

    always_comb begin
        vstart_sel = 1'b0;
        if (take_m)
            vstart_sel = !pcs.keep_vstart_m && !dmem_wait;
        else if (pcs.vvalid_e)
            vstart_sel = !pcs.keep_vstart_e;
    end

    assign trap.velem_num = pcs.vuop_last ? '0 :
                            take_m        ? pcs.velem_num_m : pcs.velem_num_e;

    // only update vstart when something is actually trapping
    assign trap.set_vstart = pcs.vuop_last
                          || ((exception || (prv.intr && !not_interruptible)) && vstart_sel);

    // fault vector, protection faults folded into load/store faults
    always_comb begin
        trap.fault         = faults;
        trap.fault.fault_l = faults.fault_l || prv.prot_fault_l;
        trap.fault.fault_s = faults.fault_s || prv.prot_fault_s;
    end

    assign trap.badaddr    = badaddr;
    assign trap.vuop_last  = pcs.vuop_last;
    assign trap.pipe_clear = !dmem_wait && !not_interruptible;
    assign trap.wb_enable  = !if_ex_stall || jump || branch; // insn retires this cycle
    assign trap.ret        = prv.ret;

endmodule

`default_nettype wire

/* src/pipe_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  pipe_ctrl_pkg::scalar_hz_t    scalar,
    input  pipe_ctrl_pkg::vec_hz_t       vec,
    input  pipe_ctrl_pkg::stage_status_t status,
    input  pipe_ctrl_pkg::fault_t        faults,
    input  pipe_ctrl_pkg::pc_track_t     pcs,
    input  pipe_ctrl_pkg::word_t         badaddr,
    input  logic                         vsetvl_dec, // vsetvl in decode
    input  logic                         vsetvl_ex,  // vsetvl reached execute
    input  pipe_ctrl_pkg::prv_in_t       prv,
    input  logic                         push,       // fetch packet valid
    input  pipe_ctrl_pkg::fetch_pkt_t    fetch_pkt,
    output pipe_ctrl_pkg::stage_ctrl_t   ctrl,
    output pipe_ctrl_pkg::trap_req_t     trap,
    output logic                         intr_taken,
    output pipe_ctrl_pkg::fetch_pkt_t    head,
    output logic                         head_valid
);

    logic exception;
    logic dmem_wait;
    logic full, empty;
    logic accepted_push;
    logic pop;

    assign head_valid = !empty;

    insn_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
        .CLK, .nRST,
        .push, .wdata(fetch_pkt),
        .pop, .flush(ctrl.flush_queue),
        .rdata(head), .empty, .full, .accepted_push
    );

    hazard_unit hazard0 (
        .CLK, .nRST,
        .scalar, .vec, .status, .prv,
        .exception, .intr_taken,
        .full, .accepted_push, .empty,
        .vsetvl_dec, .vsetvl_ex,
        .ctrl, .dmem_wait, .pop
    );

    trap_select trap0 (
        .faults, .prv, .pcs, .badaddr,
        .dmem_wait, .if_ex_stall(ctrl.if_ex_stall),
        .jump(status.jump), .branch(status.branch),
        .not_interruptible(status.not_interruptible),
        .exception, .intr_taken, .trap
    );

endmodule

`default_nettype wire

/* tb/tb_pipe_ctrl_ref.svh */
`ifndef TB_PIPE_CTRL_REF_SVH
`define TB_PIPE_CTRL_REF_SVH

pipe_ctrl_pkg::fetch_pkt_t model_q[$]; // packets the queue should hold, head first
logic vset_flag = 1'b0;                 // decode held behind a vsetvl

function automatic logic any_exception(input pipe_ctrl_pkg::fault_t f,
                                       input pipe_ctrl_pkg::prv_in_t p);
    return (f != '0) || p.prot_fault_l || p.prot_fault_s;
endfunction

// mem access in progress that the bus has not finished
function automatic logic data_wait(input pipe_ctrl_pkg::scalar_hz_t s,
                                   input pipe_ctrl_pkg::stage_status_t t, input logic exc);
    return (s.dren || s.dwen) && t.d_mem_busy && !exc;
endfunction

function automatic logic vec_dep(input pipe_ctrl_pkg::vec_hz_t v);
    return v.vregwen && ((v.vs1_used && v.vd == v.vs1) || (v.vs2_used && v.vd == v.vs2)
                      || (v.ex_mask_dep && v.vd == 5'd0) || (v.vd_used && v.vd == v.vd_ex));
endfunction

function automatic pipe_ctrl_pkg::stage_ctrl_t exp_ctrl(
    input pipe_ctrl_pkg::scalar_hz_t s, input pipe_ctrl_pkg::vec_hz_t v,
    input pipe_ctrl_pkg::stage_status_t t, input pipe_ctrl_pkg::prv_in_t p,
    input pipe_ctrl_pkg::fault_t f, input logic q_full, input logic vwait);
    pipe_ctrl_pkg::stage_ctrl_t c;
    logic exc, dw, redirect, trap_flush, ld_use, vdep, imem_wait;
    exc        = any_exception(f, p);
    dw         = data_wait(s, t, exc);
    redirect   = t.jump || (t.branch && t.mispredict);
    // interrupt only between mem accesses and on interruptible insns
    trap_flush = exc || p.ret || (t.ifence && !t.fence_stall)
              || (p.intr && !exc && !dw && !t.not_interruptible);
    ld_use     = s.reg_write && (s.dren || s.csr_read) && s.rd_m != 5'd0
              && (s.rs1_e == s.rd_m || s.rs2_e == s.rd_m);
    vdep       = vec_dep(v);
    c.suppress_iren = redirect || trap_flush || p.insert_pc;
    imem_wait  = t.iren && t.i_mem_busy && !c.suppress_iren && !t.rv32c_ready;
    c.ex_mem_stall = dw || t.fence_stall || t.serializer_stall || t.coalescer_stall || t.halt;
    c.stall_queue  = c.ex_mem_stall || ld_use || t.fence_stall || vdep
                  || (t.ex_busy && !trap_flush && !redirect);
    c.flush_queue  = trap_flush || redirect;
    c.flush_decode = c.flush_queue;
    c.stall_decode = (q_full && !c.flush_queue) || vwait;
    c.if_ex_stall  = c.stall_decode || t.fence_stall || (v.vbusy && !c.flush_queue);
    c.pc_en        = (!c.if_ex_stall && !c.stall_queue && !imem_wait) || redirect
                  || p.insert_pc || p.ret;
    c.npc_sel      = redirect;
    c.if_ex_flush  = redirect || trap_flush || imem_wait;
    c.ex_mem_flush = (c.flush_queue || c.stall_queue) && !c.ex_mem_stall; // mem holds wins
    c.mem_use_stall    = ld_use;
    c.vmem_use_stall   = vdep;
    c.vmask_calc_stall = c.ex_mem_stall || ld_use || t.fence_stall || vdep;
    c.suppress_data    = exc;
    c.rollback         = t.ifence && !t.fence_stall;
    c.insert_priv_pc   = p.insert_pc;
    c.priv_pc          = p.priv_pc;
    return c;
endfunction

function automatic pipe_ctrl_pkg::trap_req_t exp_trap(
    input pipe_ctrl_pkg::fault_t f, input pipe_ctrl_pkg::prv_in_t p,
    input pipe_ctrl_pkg::pc_track_t k, input pipe_ctrl_pkg::word_t bad,
    input pipe_ctrl_pkg::scalar_hz_t s, input pipe_ctrl_pkg::stage_status_t t,
    input logic stall_fe);
    pipe_ctrl_pkg::trap_req_t r;
    logic exc, dw, use_m, vs_ok;
    exc   = any_exception(f, p);
    dw    = data_wait(s, t, exc);
    use_m = k.valid_m && !(p.intr && !exc && k.vmem_last_elem); // last element done on intr
    r.fault = f;
    r.fault.fault_l = f.fault_l || p.prot_fault_l;
    r.fault.fault_s = f.fault_s || p.prot_fault_s;
    if (use_m)
        r.epc = k.pc_m;
    else if (k.valid_e)
        r.epc = k.pc_e;
    else if (k.valid_decode)
        r.epc = k.pc_decode;
    else
        r.epc = k.pc_f;
    vs_ok = use_m ? (!k.keep_vstart_m && !dw) : (k.vvalid_e && !k.keep_vstart_e);
    r.velem_num  = k.vuop_last ? 8'd0 : (use_m ? k.velem_num_m : k.velem_num_e);
    r.set_vstart = k.vuop_last || ((exc || (p.intr && !t.not_interruptible)) && vs_ok);
    r.badaddr    = bad;
    r.vuop_last  = k.vuop_last;
    r.pipe_clear = !dw && !t.not_interruptible;
    r.wb_enable  = !stall_fe || t.jump || t.branch;
    r.ret        = p.ret;
    return r;
endfunction

// advance queue contents and vsetvl flag across one clock edge
task automatic step_model(input pipe_ctrl_pkg::stage_ctrl_t c, input logic push_in,
                          input pipe_ctrl_pkg::fetch_pkt_t pkt_in, input logic dec,
                          input logic ex);
    logic take_push, take_pop;
    take_push = push_in && (model_q.size() != QUEUE_DEPTH); // dropped when full
    take_pop  = (model_q.size() != 0) && !c.stall_decode && !c.if_ex_stall;
    if (c.flush_queue || ex)
        vset_flag = 1'b0;
    else if (take_push && dec)
        vset_flag = 1'b1;
    if (c.flush_queue) begin
        model_q.delete();
    end else begin
        if (take_pop)
            void'(model_q.pop_front());
        if (take_push)
            model_q.push_back(pkt_in);
    end
endtask

`endif

/* tb/tb_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl;

    localparam int QUEUE_DEPTH = 4;
    localparam int SWEEP_N     = 300; // random status cycles, no faults
    localparam int TRAP_N      = 300; // random cycles with faults
    localparam int DIRECTED_N  = 80;  // reset, stall, queue and vsetvl steps
    localparam int TEST_CYCLES = SWEEP_N + TRAP_N + DIRECTED_N;

    logic CLK = 1'b0;
    logic nRST;
    pipe_ctrl_pkg::scalar_hz_t    sc;
    pipe_ctrl_pkg::vec_hz_t       vc;
    pipe_ctrl_pkg::stage_status_t st;
    pipe_ctrl_pkg::fault_t        fl;
    pipe_ctrl_pkg::pc_track_t     pcs;
    pipe_ctrl_pkg::word_t         badaddr;
    pipe_ctrl_pkg::prv_in_t       pv;
    pipe_ctrl_pkg::fetch_pkt_t    pkt, head;
    pipe_ctrl_pkg::stage_ctrl_t   ctrl;
    pipe_ctrl_pkg::trap_req_t     trap;
    logic vdec, vex, push;
    logic intr_taken, head_valid;
    logic [31:0] seed = 32'h9458144d;

    `include "tb_pipe_ctrl_ref.svh"

    always #4 CLK = ~CLK; // 8 ns period

    pipe_ctrl_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
        .CLK, .nRST, .scalar(sc), .vec(vc), .status(st), .faults(fl), .pcs, .badaddr,
        .vsetvl_dec(vdec), .vsetvl_ex(vex), .prv(pv), .push, .fetch_pkt(pkt),
        .ctrl, .trap, .intr_taken, .head, .head_valid
    );

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223; // LCG step
        return seed;
    endfunction

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ctrl(input string name, input pipe_ctrl_pkg::stage_ctrl_t got,
                              input pipe_ctrl_pkg::stage_ctrl_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_trap(input string name, input pipe_ctrl_pkg::trap_req_t got,
                              input pipe_ctrl_pkg::trap_req_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_pkt(input string name, input pipe_ctrl_pkg::fetch_pkt_t got,
                             input pipe_ctrl_pkg::fetch_pkt_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic quiet();
        sc      <= '0;
        vc      <= '0;
        st      <= '0;
        fl      <= '0;
        pcs     <= '0;
        pv      <= '0;
        badaddr <= '0;
        push    <= 1'b0;
        pkt     <= '0;
        vdec    <= 1'b0;
        vex     <= 1'b0;
    endtask

    // fetch pushes one packet, vbusy optionally holds decode
    task automatic send_pkt(input logic hold);
        @(posedge CLK);
        quiet();
        vc.vbusy <= hold;
        push     <= 1'b1;
        pkt.pc   <= next_random();
        pkt.insn <= next_random();
    endtask

    task automatic idle_cycles(input int n, input logic hold);
        repeat (n) begin
            @(posedge CLK);
            quiet();
            vc.vbusy <= hold;
        end
    endtask

    task automatic random_inputs(input logic with_faults);
        logic [31:0] r0, r1, r2, r3, r4;
        @(posedge CLK);
        r0 = next_random();
        r1 = next_random();
        r2 = next_random();
        r3 = next_random();
        r4 = next_random();
        st <= pipe_ctrl_pkg::stage_status_t'(r0[13:0] & r1[13:0]); // sparse status
        sc.rs1_e <= {3'b000, r2[1:0]}; // small indices so matches happen
        sc.rs2_e <= {3'b000, r2[3:2]};
        sc.rd_m  <= {3'b000, r2[5:4]};
        {sc.reg_write, sc.dren, sc.dwen, sc.csr_read} <= r2[9:6];
        vc.vd    <= {3'b000, r3[1:0]};
        vc.vs1   <= {3'b000, r3[3:2]};
        vc.vs2   <= {3'b000, r3[5:4]};
        vc.vd_ex <= {3'b000, r3[7:6]};
        {vc.vregwen, vc.vs1_used, vc.vs2_used, vc.vd_used, vc.ex_mask_dep} <= r3[12:8];
        vc.vbusy <= r3[13] & r3[14];
        pv.intr <= r1[20];
        pv.ret  <= r1[21] & r1[22];
        pv.insert_pc    <= r1[23] & r1[24];
        pv.priv_pc      <= r0;
        pv.prot_fault_l <= with_faults & r1[29] & r1[30];
        pv.prot_fault_s <= with_faults & r1[31] & r2[30];
        fl <= (with_faults && r2[31]) ? pipe_ctrl_pkg::fault_t'(r2[19:10] & r4[19:10]) : '0;
        pcs.pc_f      <= next_random();
        pcs.pc_decode <= next_random();
        pcs.pc_e      <= next_random();
        pcs.pc_m      <= next_random();
        pcs.velem_num_e <= r0[23:16];
        pcs.velem_num_m <= r0[31:24];
        {pcs.valid_decode, pcs.valid_e, pcs.valid_m, pcs.vvalid_e, pcs.vmem_last_elem,
         pcs.vuop_last, pcs.keep_vstart_e, pcs.keep_vstart_m} <= r4[27:20];
        badaddr  <= next_random();
        push     <= r1[25];
        pkt.pc   <= next_random();
        pkt.insn <= next_random();
        vdec     <= r1[26] & r1[27];
        vex      <= r1[28];
    endtask

    // compare 1 ns before each rising edge, then step the model over that edge
    initial begin
        pipe_ctrl_pkg::stage_ctrl_t c_exp;
        pipe_ctrl_pkg::trap_req_t   t_exp;
        forever begin
            @(posedge CLK);
            #7;
            if (nRST === 1'b1) begin
                c_exp = exp_ctrl(sc, vc, st, pv, fl, model_q.size() == QUEUE_DEPTH, vset_flag);
                t_exp = exp_trap(fl, pv, pcs, badaddr, sc, st, c_exp.if_ex_stall);
                check_ctrl("ctrl", ctrl, c_exp);
                check_trap("trap", trap, t_exp);
                // a fault in the same cycle keeps the interrupt pending
                check_bit("intr_taken", intr_taken, pv.intr && !any_exception(fl, pv));
                check_bit("head_valid", head_valid, model_q.size() != 0);
                if (model_q.size() != 0)
                    check_pkt("head", head, model_q[0]);
                step_model(c_exp, push, pkt, vdec, vex);
            end
        end
    end

    initial begin
        #((TEST_CYCLES + 100) * 8);
        $display("watchdog expired before the test sequence finished");
        stop_with_failure();
    end

    initial begin
        nRST <= 1'b0;
        quiet();
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        // load in mem feeding execute, rs1 then rs2, then x0
        @(posedge CLK);
        quiet();
        sc.reg_write <= 1'b1;
        sc.dren      <= 1'b1;
        sc.rd_m      <= 5'd5;
        sc.rs1_e     <= 5'd5;
        @(posedge CLK);
        sc.rs1_e <= 5'd1;
        sc.rs2_e <= 5'd5;
        @(posedge CLK);
        sc.rd_m  <= 5'd0;
        sc.rs1_e <= 5'd0;
        sc.rs2_e <= 5'd0;
        // vector deps in check order
        @(posedge CLK);
        quiet();
        vc.vregwen  <= 1'b1;
        vc.vd       <= 5'd3;
        vc.vs1      <= 5'd3;
        vc.vs1_used <= 1'b1;
        @(posedge CLK);
        vc.vs1_used <= 1'b0;
        vc.vs2      <= 5'd3;
        vc.vs2_used <= 1'b1;
        @(posedge CLK);
        vc.vs2_used    <= 1'b0;
        vc.vd          <= 5'd0;
        vc.ex_mask_dep <= 1'b1; // v0 mask
        @(posedge CLK);
        vc.ex_mask_dep <= 1'b0;
        vc.vd          <= 5'd7;
        vc.vd_ex       <= 5'd7;
        vc.vd_used     <= 1'b1;
        repeat (SWEEP_N) random_inputs(1'b0);
        repeat (TRAP_N) random_inputs(1'b1);
        // queue flow, back-pressure with a dropped fifth push, then redirect
        idle_cycles(2, 1'b0);
        repeat (3) send_pkt(1'b0);
        idle_cycles(3, 1'b0);
        repeat (5) send_pkt(1'b1);
        idle_cycles(2, 1'b1);
        idle_cycles(6, 1'b0);
        repeat (2) send_pkt(1'b1);
        @(posedge CLK);
        quiet();
        st.jump <= 1'b1; // flush_queue
        idle_cycles(2, 1'b0);
        // vsetvl wait released by execute, then by a flush
        send_pkt(1'b0);
        vdec <= 1'b1;
        idle_cycles(4, 1'b0);
        @(posedge CLK);
        quiet();
        vex <= 1'b1;
        idle_cycles(2, 1'b0);
        send_pkt(1'b0);
        vdec <= 1'b1;
        idle_cycles(2, 1'b0);
        @(posedge CLK);
        quiet();
        st.jump <= 1'b1;
        idle_cycles(3, 1'b0);
        @(posedge CLK);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* pipe_ctrl.f */
+incdir+tb
common/pipe_ctrl_pkg.sv
src/insn_queue.sv
hazard/hazard_unit.sv
hazard/trap_select.sv
src/pipe_ctrl_top.sv
tb/tb_pipe_ctrl.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_pipe_ctrl
FILELIST  := pipe_ctrl.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) --Mdir $(OBJDIR)

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) tb/tb_pipe_ctrl_ref.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
